// File: src/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // ==============================
  // sizes
  // ==============================
  localparam int DATA_WIDTH      = 64;
  localparam int ADDR_WIDTH      = 12;
  localparam int MEM_WORDS       = 512;
  localparam int MASK_WIDTH      = DATA_WIDTH / 8;               // one bit per byte lane
  localparam int OFFSET_WIDTH    = $clog2(MASK_WIDTH);           // byte offset inside a word
  localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - OFFSET_WIDTH;

  typedef logic [DATA_WIDTH-1:0]      data_t;
  typedef logic [ADDR_WIDTH-1:0]      addr_t;
  typedef logic [WORD_ADDR_WIDTH-1:0] word_addr_t;
  typedef logic [MASK_WIDTH-1:0]      mask_t;

  // ==============================
  // opcodes
  // ==============================
  typedef enum logic [4:0] {
    LB,
    LH,
    LW,
    LD,
    LBU,
    LHU,
    LWU,
    SB,
    SH,
    SW,
    SD,
    SM,
    LM,
    AMOSWAP_W,
    AMOADD_W,
    AMOXOR_W,
    AMOAND_W,
    AMOOR_W,
    AMOMIN_W,
    AMOMAX_W,
    AMOMINU_W,
    AMOMAXU_W,
    AMOSWAP_D,                     // double forms keep the same order as the word forms
    AMOADD_D,
    AMOXOR_D,
    AMOAND_D,
    AMOOR_D,
    AMOMIN_D,
    AMOMAX_D,
    AMOMINU_D,
    AMOMAXU_D
  } opcode_e;

endpackage

`default_nettype wire

// File: src/data_ram.sv
`timescale 1ns/1ns
`default_nettype none

module data_ram (
  input  wire                      clk_i,
  input  wire mem_pkg::word_addr_t rd_addr_i,
  output mem_pkg::data_t           rd_data_o,
  input  wire                      wr_en_i,
  input  wire mem_pkg::word_addr_t wr_addr_i,
  input  wire mem_pkg::data_t      wr_data_i,
  input  wire mem_pkg::mask_t      wr_mask_i
);

  mem_pkg::data_t mem [mem_pkg::MEM_WORDS];

  always_ff @(posedge clk_i) begin
    rd_data_o <= mem[rd_addr_i];  // returns the old word when a write hits the same index
  end

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      for (int b = 0; b < mem_pkg::MASK_WIDTH; b++) begin
        if (wr_mask_i[b]) begin
          mem[wr_addr_i][8*b +: 8] <= wr_data_i[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/load_align.sv
`timescale 1ns/1ns
`default_nettype none

module load_align (
  input  wire mem_pkg::opcode_e opcode_i,
  input  wire mem_pkg::addr_t   addr_i,
  input  wire mem_pkg::mask_t   mask_i,
  input  wire mem_pkg::data_t   word_i,
  output mem_pkg::data_t        data_o
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;
  logic [31:0] word_sel;

  // wider lanes ignore the finer address bits
  assign byte_sel = word_i[{addr_i[mem_pkg::OFFSET_WIDTH-1:0], 3'b000} +: 8];
  assign half_sel = word_i[{addr_i[2:1], 4'b0000} +: 16];
  assign word_sel = word_i[{addr_i[2], 5'b00000} +: 32];

  always_comb begin
    case (opcode_i)
      mem_pkg::LB:  data_o = {{(mem_pkg::DATA_WIDTH-8){byte_sel[7]}}, byte_sel};
      mem_pkg::LBU: data_o = {{(mem_pkg::DATA_WIDTH-8){1'b0}}, byte_sel};
      mem_pkg::LH:  data_o = {{(mem_pkg::DATA_WIDTH-16){half_sel[15]}}, half_sel};
      mem_pkg::LHU: data_o = {{(mem_pkg::DATA_WIDTH-16){1'b0}}, half_sel};
      mem_pkg::LWU: data_o = {{(mem_pkg::DATA_WIDTH-32){1'b0}}, word_sel};

      mem_pkg::LW, mem_pkg::AMOSWAP_W, mem_pkg::AMOADD_W, mem_pkg::AMOXOR_W,
      mem_pkg::AMOAND_W, mem_pkg::AMOOR_W, mem_pkg::AMOMIN_W, mem_pkg::AMOMAX_W,
      mem_pkg::AMOMINU_W, mem_pkg::AMOMAXU_W: begin
        data_o = {{(mem_pkg::DATA_WIDTH-32){word_sel[31]}}, word_sel};  // old value for atomics
      end

      mem_pkg::LD, mem_pkg::AMOSWAP_D, mem_pkg::AMOADD_D, mem_pkg::AMOXOR_D,
      mem_pkg::AMOAND_D, mem_pkg::AMOOR_D, mem_pkg::AMOMIN_D, mem_pkg::AMOMAX_D,
      mem_pkg::AMOMINU_D, mem_pkg::AMOMAXU_D: begin
        data_o = word_i;
      end

      mem_pkg::LM: begin
        for (int b = 0; b < mem_pkg::MASK_WIDTH; b++) begin
          data_o[8*b +: 8] = mask_i[b] ? word_i[8*b +: 8] : 8'h00;
        end
      end

      default: data_o = '0;  // stores and the masked store return zero
    endcase
  end

endmodule

`default_nettype wire

// File: src/store_gen.sv
`timescale 1ns/1ns
`default_nettype none

module store_gen (
  input  wire mem_pkg::opcode_e opcode_i,
  input  wire mem_pkg::addr_t   addr_i,
  input  wire mem_pkg::data_t   data_i,
  input  wire mem_pkg::mask_t   mask_i,
  input  wire mem_pkg::data_t   old_i,
  output logic                  wr_en_o,
  output mem_pkg::data_t        wr_data_o,
  output mem_pkg::mask_t        wr_mask_o
);

  logic [31:0]    op_w;
  logic [31:0]    old_w;
  mem_pkg::data_t pre_data;

  assign op_w  = data_i[31:0];
  assign old_w = old_i[31:0];

  // ==============================
  // atomic arithmetic
  // ==============================
  always_comb begin
    case (opcode_i)
      mem_pkg::AMOADD_W: pre_data = {32'b0, op_w + old_w};
      mem_pkg::AMOXOR_W: pre_data = {32'b0, op_w ^ old_w};
      mem_pkg::AMOAND_W: pre_data = {32'b0, op_w & old_w};
      mem_pkg::AMOOR_W:  pre_data = {32'b0, op_w | old_w};
      mem_pkg::AMOMIN_W: pre_data = {32'b0, ($signed(op_w) < $signed(old_w)) ? op_w : old_w};
      mem_pkg::AMOMAX_W: pre_data = {32'b0, ($signed(op_w) > $signed(old_w)) ? op_w : old_w};
      mem_pkg::AMOMINU_W: pre_data = {32'b0, (op_w < old_w) ? op_w : old_w};
      mem_pkg::AMOMAXU_W: pre_data = {32'b0, (op_w > old_w) ? op_w : old_w};

      mem_pkg::AMOADD_D: pre_data = data_i + old_i;
      mem_pkg::AMOXOR_D: pre_data = data_i ^ old_i;
      mem_pkg::AMOAND_D: pre_data = data_i & old_i;
      mem_pkg::AMOOR_D:  pre_data = data_i | old_i;
      mem_pkg::AMOMIN_D: pre_data = ($signed(data_i) < $signed(old_i)) ? data_i : old_i;
      mem_pkg::AMOMAX_D: pre_data = ($signed(data_i) > $signed(old_i)) ? data_i : old_i;
      mem_pkg::AMOMINU_D: pre_data = (data_i < old_i) ? data_i : old_i;
      mem_pkg::AMOMAXU_D: pre_data = (data_i > old_i) ? data_i : old_i;

      default: pre_data = data_i;  // plain stores and swaps write the operand
    endcase
  end

  // ==============================
  // lane replication and mask
  // ==============================
  always_comb begin
    wr_en_o   = 1'b1;
    wr_data_o = '0;
    wr_mask_o = '0;
    case (opcode_i)
      mem_pkg::SB: begin
        wr_data_o = {(mem_pkg::DATA_WIDTH/8){pre_data[7:0]}};
        wr_mask_o = mem_pkg::mask_t'(1) << addr_i[mem_pkg::OFFSET_WIDTH-1:0];
      end

      mem_pkg::SH: begin
        wr_data_o = {(mem_pkg::DATA_WIDTH/16){pre_data[15:0]}};
        wr_mask_o = mem_pkg::mask_t'(2'b11) << {addr_i[2:1], 1'b0};
      end

      mem_pkg::SW, mem_pkg::AMOSWAP_W, mem_pkg::AMOADD_W, mem_pkg::AMOXOR_W,
      mem_pkg::AMOAND_W, mem_pkg::AMOOR_W, mem_pkg::AMOMIN_W, mem_pkg::AMOMAX_W,
      mem_pkg::AMOMINU_W, mem_pkg::AMOMAXU_W: begin
        wr_data_o = {(mem_pkg::DATA_WIDTH/32){pre_data[31:0]}};
        wr_mask_o = addr_i[2] ? 8'hf0 : 8'h0f;
      end

      mem_pkg::SD, mem_pkg::AMOSWAP_D, mem_pkg::AMOADD_D, mem_pkg::AMOXOR_D,
      mem_pkg::AMOAND_D, mem_pkg::AMOOR_D, mem_pkg::AMOMIN_D, mem_pkg::AMOMAX_D,
      mem_pkg::AMOMINU_D, mem_pkg::AMOMAXU_D: begin
        wr_data_o = pre_data;
        wr_mask_o = '1;
      end

      mem_pkg::SM: begin
        wr_data_o = pre_data;
        wr_mask_o = mask_i;  // caller picks the bytes directly
      end

      default: wr_en_o = 1'b0;  // loads leave the RAM alone
    endcase
  end

endmodule

`default_nettype wire

// File: src/mem_access_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module mem_access_ctrl (
  input  wire                      clk_i,
  input  wire                      reset_i,
  input  wire                      v_i,
  input  wire mem_pkg::opcode_e    opcode_i,
  input  wire mem_pkg::addr_t      addr_i,
  input  wire mem_pkg::data_t      data_i,
  input  wire mem_pkg::mask_t      mask_i,
  output logic                     ready_o,
  output logic                     v_o,
  output mem_pkg::data_t           data_o,
  input  wire                      yumi_i,
  output mem_pkg::word_addr_t      rd_addr_o,
  input  wire mem_pkg::data_t      rd_data_i,
  output logic                     wr_en_o,
  output mem_pkg::word_addr_t      wr_addr_o,
  output mem_pkg::data_t           wr_data_o,
  output mem_pkg::mask_t           wr_mask_o,
  output mem_pkg::opcode_e         s2_opcode_o,
  output mem_pkg::addr_t           s2_addr_o,
  output mem_pkg::data_t           s2_data_o,
  output mem_pkg::mask_t           s2_mask_o,
  output mem_pkg::data_t           s2_word_o,
  input  wire mem_pkg::data_t      load_i,
  input  wire                      st_en_i,
  input  wire mem_pkg::data_t      st_data_i,
  input  wire mem_pkg::mask_t      st_mask_i
);

  logic                s1_v;
  mem_pkg::opcode_e    s1_opcode;
  mem_pkg::addr_t      s1_addr;
  mem_pkg::data_t      s1_data;
  mem_pkg::mask_t      s1_mask;
  mem_pkg::word_addr_t s1_idx;

  logic                fwd_v;
  mem_pkg::word_addr_t fwd_idx;
  mem_pkg::data_t      fwd_word;
  mem_pkg::data_t      new_word;

  logic                clearing;
  mem_pkg::word_addr_t clear_idx;

  logic                accept;
  logic                s2_adv;

  // ==============================
  // handshakes
  // ==============================
  assign s2_adv  = s1_v & (~v_o | yumi_i);        // output register empty or drained now
  assign ready_o = ~clearing & (~s1_v | s2_adv);
  assign accept  = v_i & ready_o;

  assign s1_idx    = s1_addr[mem_pkg::ADDR_WIDTH-1:mem_pkg::OFFSET_WIDTH];
  assign rd_addr_o = accept ? addr_i[mem_pkg::ADDR_WIDTH-1:mem_pkg::OFFSET_WIDTH] : s1_idx;

  assign s2_opcode_o = s1_opcode;
  assign s2_addr_o   = s1_addr;
  assign s2_data_o   = s1_data;
  assign s2_mask_o   = s1_mask;
  assign s2_word_o   = (fwd_v && fwd_idx == s1_idx) ? fwd_word : rd_data_i;

  // ==============================
  // RAM write port
  // ==============================
  assign wr_en_o   = clearing | (s2_adv & st_en_i);  // an atomic stalled in stage 2 writes once
  assign wr_addr_o = clearing ? clear_idx : s1_idx;
  assign wr_data_o = clearing ? '0 : st_data_i;
  assign wr_mask_o = clearing ? '1 : st_mask_i;

  // full content of the word after this cycle's write
  always_comb begin
    for (int b = 0; b < mem_pkg::MASK_WIDTH; b++) begin
      new_word[8*b +: 8] = wr_mask_o[b] ? wr_data_o[8*b +: 8] : s2_word_o[8*b +: 8];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_v     <= 1'b0;
      fwd_v    <= 1'b0;
      v_o      <= 1'b0;
      clearing <= 1'b1;
      clear_idx <= '0;
    end else begin
      s1_v  <= accept | (s1_v & ~s2_adv);
      fwd_v <= wr_en_o;
      v_o   <= s2_adv | (v_o & ~yumi_i);
      if (clearing) begin
        clear_idx <= clear_idx + 1'b1;
        if (clear_idx == mem_pkg::word_addr_t'(mem_pkg::MEM_WORDS - 1)) begin
          clearing <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      s1_opcode <= opcode_i;
      s1_addr   <= addr_i;
      s1_data   <= data_i;
      s1_mask   <= mask_i;
    end
    if (wr_en_o) begin
      fwd_idx  <= wr_addr_o;
      fwd_word <= new_word;
    end
    if (s2_adv) begin
      data_o <= load_i;
    end
  end

endmodule

`default_nettype wire

// File: src/mem_access_unit.sv
`timescale 1ns/1ns
`default_nettype none

module mem_access_unit (
  input  wire                   clk_i,
  input  wire                   reset_i,
  input  wire                   v_i,
  input  wire mem_pkg::opcode_e opcode_i,
  input  wire mem_pkg::addr_t   addr_i,
  input  wire mem_pkg::data_t   data_i,
  input  wire mem_pkg::mask_t   mask_i,
  output logic                  ready_o,
  output logic                  v_o,
  output mem_pkg::data_t        data_o,
  input  wire                   yumi_i
);

  mem_pkg::word_addr_t rd_addr;
  mem_pkg::data_t      rd_data;
  logic                wr_en;
  mem_pkg::word_addr_t wr_addr;
  mem_pkg::data_t      wr_data;
  mem_pkg::mask_t      wr_mask;

  mem_pkg::opcode_e    s2_opcode;
  mem_pkg::addr_t      s2_addr;
  mem_pkg::data_t      s2_data;
  mem_pkg::mask_t      s2_mask;
  mem_pkg::data_t      s2_word;
  mem_pkg::data_t      load_data;
  logic                st_en;
  mem_pkg::data_t      st_data;
  mem_pkg::mask_t      st_mask;

  mem_access_ctrl ctrl (
    .clk_i(clk_i), .reset_i(reset_i),
    .v_i(v_i), .opcode_i(opcode_i), .addr_i(addr_i), .data_i(data_i), .mask_i(mask_i),
    .ready_o(ready_o), .v_o(v_o), .data_o(data_o), .yumi_i(yumi_i),
    .rd_addr_o(rd_addr), .rd_data_i(rd_data),
    .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data), .wr_mask_o(wr_mask),
    .s2_opcode_o(s2_opcode), .s2_addr_o(s2_addr), .s2_data_o(s2_data),
    .s2_mask_o(s2_mask), .s2_word_o(s2_word), .load_i(load_data),
    .st_en_i(st_en), .st_data_i(st_data), .st_mask_i(st_mask)
  );

  data_ram ram (
    .clk_i(clk_i), .rd_addr_i(rd_addr), .rd_data_o(rd_data),
    .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data), .wr_mask_i(wr_mask)
  );

  load_align align (
    .opcode_i(s2_opcode), .addr_i(s2_addr), .mask_i(s2_mask),
    .word_i(s2_word), .data_o(load_data)
  );

  store_gen stgen (
    .opcode_i(s2_opcode), .addr_i(s2_addr), .data_i(s2_data), .mask_i(s2_mask),
    .old_i(load_data), .wr_en_o(st_en), .wr_data_o(st_data), .wr_mask_o(st_mask)
  );

endmodule

`default_nettype wire

// File: include/ref_model.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

typedef mem_pkg::data_t shadow_mem_t [mem_pkg::MEM_WORDS];

function automatic mem_pkg::word_addr_t ref_index(mem_pkg::addr_t addr);
  return addr[mem_pkg::ADDR_WIDTH-1:mem_pkg::OFFSET_WIDTH];
endfunction

// expected result of one request against the current shadow word
function automatic mem_pkg::data_t ref_expected(mem_pkg::opcode_e op, mem_pkg::addr_t addr,
                                                mem_pkg::mask_t mask, mem_pkg::data_t word);
  logic [7:0]     b;
  logic [15:0]    h;
  logic [31:0]    w;
  mem_pkg::data_t res;
  b = word[{addr[2:0], 3'b000} +: 8];
  h = word[{addr[2:1], 4'b0000} +: 16];
  w = word[{addr[2], 5'b00000} +: 32];
  res = '0;
  if (op inside {mem_pkg::LB})  res = {{56{b[7]}}, b};
  if (op inside {mem_pkg::LBU}) res = {56'b0, b};
  if (op inside {mem_pkg::LH})  res = {{48{h[15]}}, h};
  if (op inside {mem_pkg::LHU}) res = {48'b0, h};
  if (op inside {mem_pkg::LWU}) res = {32'b0, w};
  if (op inside {mem_pkg::LW, [mem_pkg::AMOSWAP_W:mem_pkg::AMOMAXU_W]}) res = {{32{w[31]}}, w};
  if (op inside {mem_pkg::LD, [mem_pkg::AMOSWAP_D:mem_pkg::AMOMAXU_D]}) res = word;
  if (op == mem_pkg::LM) begin
    for (int i = 0; i < mem_pkg::MASK_WIDTH; i++) begin
      res[8*i +: 8] = mask[i] ? word[8*i +: 8] : 8'h00;
    end
  end
  return res;
endfunction

// word operands arrive extended so that 64-bit order matches 32-bit order
function automatic mem_pkg::data_t ref_amo(mem_pkg::opcode_e op, mem_pkg::data_t a,
                                           mem_pkg::data_t o);
  case (op)
    mem_pkg::AMOADD_W, mem_pkg::AMOADD_D:   return a + o;
    mem_pkg::AMOXOR_W, mem_pkg::AMOXOR_D:   return a ^ o;
    mem_pkg::AMOAND_W, mem_pkg::AMOAND_D:   return a & o;
    mem_pkg::AMOOR_W, mem_pkg::AMOOR_D:     return a | o;
    mem_pkg::AMOMIN_W, mem_pkg::AMOMIN_D:   return ($signed(a) < $signed(o)) ? a : o;
    mem_pkg::AMOMAX_W, mem_pkg::AMOMAX_D:   return ($signed(a) > $signed(o)) ? a : o;
    mem_pkg::AMOMINU_W, mem_pkg::AMOMINU_D: return (a < o) ? a : o;
    mem_pkg::AMOMAXU_W, mem_pkg::AMOMAXU_D: return (a > o) ? a : o;
    default:                                return a;
  endcase
endfunction

// new shadow word after one request
function automatic mem_pkg::data_t ref_update(mem_pkg::opcode_e op, mem_pkg::addr_t addr,
                                              mem_pkg::data_t data, mem_pkg::mask_t mask,
                                              mem_pkg::data_t word);
  logic           uns;
  logic [31:0]    a;
  logic [31:0]    o;
  mem_pkg::data_t r;
  mem_pkg::data_t res;
  res = word;
  a   = data[31:0];
  o   = word[{addr[2], 5'b00000} +: 32];
  uns = op inside {mem_pkg::AMOMINU_W, mem_pkg::AMOMAXU_W};
  case (op)
    mem_pkg::SB: res[{addr[2:0], 3'b000} +: 8] = data[7:0];
    mem_pkg::SH: res[{addr[2:1], 4'b0000} +: 16] = data[15:0];
    mem_pkg::SW: res[{addr[2], 5'b00000} +: 32] = data[31:0];
    mem_pkg::SD: res = data;
    mem_pkg::SM: begin
      for (int i = 0; i < mem_pkg::MASK_WIDTH; i++) begin
        if (mask[i]) res[8*i +: 8] = data[8*i +: 8];
      end
    end
    default: begin
      if (op inside {[mem_pkg::AMOSWAP_W:mem_pkg::AMOMAXU_W]}) begin
        r = uns ? ref_amo(op, {32'b0, a}, {32'b0, o})
                : ref_amo(op, {{32{a[31]}}, a}, {{32{o[31]}}, o});
        res[{addr[2], 5'b00000} +: 32] = r[31:0];
      end else if (op inside {[mem_pkg::AMOSWAP_D:mem_pkg::AMOMAXU_D]}) begin
        res = ref_amo(op, data, word);
      end
    end
  endcase
  return res;
endfunction

`endif

// File: sim/mem_access_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mem_access_unit_tb;

  `include "ref_model.svh"

  localparam int TIMEOUT = 2000;

  logic             clk_i;
  logic             reset_i;
  logic             v_i;
  mem_pkg::opcode_e opcode_i;
  mem_pkg::addr_t   addr_i;
  mem_pkg::data_t   data_i;
  mem_pkg::mask_t   mask_i;
  wire              ready_o;
  wire              v_o;
  mem_pkg::data_t   data_o;
  wire              yumi_i;

  logic             yumi_allow;
  logic             yumi_mode;
  logic [15:0]      stim_lfsr;
  logic [15:0]      yumi_lfsr;
  logic             check_latency;
  int               cyc;
  int               checks;
  int               errors;
  int               tests;
  int               start_checks;
  int               start_errors;
  string            test_name;
  shadow_mem_t      shadow;
  mem_pkg::data_t   exp_q[$];
  int               acc_q[$];
  mem_pkg::data_t   vals[4];

  mem_access_unit UUT (
    .clk_i(clk_i), .reset_i(reset_i), .v_i(v_i), .opcode_i(opcode_i), .addr_i(addr_i),
    .data_i(data_i), .mask_i(mask_i), .ready_o(ready_o), .v_o(v_o), .data_o(data_o),
    .yumi_i(yumi_i)
  );

  assign yumi_i = v_o & yumi_allow;  // yumi only while a result is offered

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ==============================
  // random source and checks
  // ==============================
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_step(stim_lfsr);
      r = {r[62:0], stim_lfsr[0]};
    end
    return r;
  endfunction

  task automatic check_data(input string name, input mem_pkg::data_t exp,
                            input mem_pkg::data_t act);
    checks++;
    if (exp !== act) begin
      $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      $display("Mismatch in %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (exp != act) begin
      $display("Mismatch in %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("%s in %s", what, test_name);
    $display("test failed");
    $finish;
  endtask

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (yumi_mode) begin
      yumi_lfsr = lfsr_step(yumi_lfsr);
      yumi_allow <= yumi_lfsr[0];
    end else begin
      yumi_allow <= 1'b1;
    end
  end

  // results are matched in request order
  always @(posedge clk_i) begin
    if (!reset_i && v_o && yumi_i) begin
      if (exp_q.size() == 0) begin
        $display("result %h arrived with no request pending in %s", data_o, test_name);
        errors++;
      end else begin
        check_data(test_name, exp_q[0], data_o);
        if (check_latency) check_count({test_name, " latency"}, 2, cyc - acc_q[0]);
        void'(exp_q.pop_front());
        void'(acc_q.pop_front());
      end
    end
  end

  // ==============================
  // request driving
  // ==============================
  task automatic send_req(input mem_pkg::opcode_e op, input mem_pkg::addr_t addr,
                          input mem_pkg::data_t data, input mem_pkg::mask_t mask);
    int                  cnt;
    mem_pkg::word_addr_t idx;
    v_i      <= 1'b1;
    opcode_i <= op;
    addr_i   <= addr;
    data_i   <= data;
    mask_i   <= mask;
    cnt = 0;
    do begin
      @(posedge clk_i);
      cnt++;
    end while (!ready_o && cnt < TIMEOUT);
    if (!ready_o) begin
      report_timeout("timed out waiting for ready_o");
    end else begin
      idx = ref_index(addr);
      exp_q.push_back(ref_expected(op, addr, mask, shadow[idx]));
      acc_q.push_back(cyc);
      shadow[idx] = ref_update(op, addr, data, mask, shadow[idx]);
    end
  endtask

  task automatic idle_cycle();
    v_i <= 1'b0;
    @(posedge clk_i);
  endtask

  task automatic start_test(input string name);
    test_name    = name;
    start_checks = checks;
    start_errors = errors;
    tests++;
  endtask

  task automatic finish_test();
    int cnt;
    v_i <= 1'b0;
    cnt = 0;
    while (exp_q.size() != 0 && cnt < TIMEOUT) begin
      @(posedge clk_i);
      cnt++;
    end
    if (exp_q.size() != 0) begin
      report_timeout("timed out waiting for v_o");
    end else begin
      @(posedge clk_i);
      check_bit({test_name, " idle v_o"}, 1'b0, v_o);  // nothing left over or duplicated
      $display("%s: %0d checks, %0d errors", test_name, checks - start_checks,
               errors - start_errors);
    end
  endtask

  // ==============================
  // directed tests
  // ==============================
  task automatic test_reset();
    int cnt;
    start_test("reset");
    check_bit("reset v_o", 1'b0, v_o);
    check_bit("reset ready_o", 1'b0, ready_o);  // the RAM clear is still running
    cnt = 0;
    while (!ready_o && cnt < TIMEOUT) begin
      @(posedge clk_i);
      cnt++;
    end
    if (!ready_o) begin
      report_timeout("timed out waiting for ready_o");
    end else begin
      for (int i = 0; i < 8; i++) begin
        send_req(mem_pkg::LD, mem_pkg::addr_t'(rand_bits(12)), '0, '0);
      end
      finish_test();
    end
  endtask

  task automatic test_lanes();
    mem_pkg::opcode_e st_ops[4];
    mem_pkg::opcode_e ld_ops[7];
    st_ops = '{mem_pkg::SB, mem_pkg::SH, mem_pkg::SW, mem_pkg::SD};
    ld_ops = '{mem_pkg::LB, mem_pkg::LBU, mem_pkg::LH, mem_pkg::LHU,
               mem_pkg::LW, mem_pkg::LWU, mem_pkg::LD};
    start_test("lanes");
    for (int s = 0; s < 4; s++) begin
      for (int off = 0; off < 8; off += (1 << s)) begin
        send_req(st_ops[s], mem_pkg::addr_t'(12'h100 + off), rand_bits(64), '0);
        for (int l = 0; l < 7; l++) send_req(ld_ops[l], mem_pkg::addr_t'(12'h100 + off), '0, '0);
      end
    end
    finish_test();
  endtask

  task automatic test_masked();
    mem_pkg::addr_t addr;
    start_test("masked");
    for (int i = 0; i < 12; i++) begin
      addr = {4'(rand_bits(4)), 8'h00};
      send_req(mem_pkg::SM, addr, rand_bits(64), mem_pkg::mask_t'(rand_bits(8)));
      send_req(mem_pkg::LM, addr, '0, mem_pkg::mask_t'(rand_bits(8)));
      send_req(mem_pkg::LM, addr, '0, mem_pkg::mask_t'(rand_bits(8)));
    end
    finish_test();
  endtask

  task automatic test_atomics();
    mem_pkg::opcode_e op;
    mem_pkg::addr_t   addr;
    start_test("atomics");
    for (int k = 0; k < 18; k++) begin
      op = mem_pkg::opcode_e'(int'(mem_pkg::AMOSWAP_W) + k);
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
          addr = mem_pkg::addr_t'(12'h140 + 4 * ((i + j) % 2));  // both word lanes
          send_req(mem_pkg::SD, addr, vals[i], '0);
          send_req(op, addr, vals[j], '0);
          send_req(mem_pkg::LD, addr, '0, '0);
        end
      end
    end
    finish_test();
  endtask

  task automatic test_back_to_back();
    start_test("back_to_back");
    check_latency = 1'b1;
    send_req(mem_pkg::SD, 12'h190, vals[2], '0);
    send_req(mem_pkg::AMOADD_D, 12'h190, vals[1], '0);
    send_req(mem_pkg::AMOXOR_D, 12'h190, vals[3], '0);
    send_req(mem_pkg::LD, 12'h190, '0, '0);
    send_req(mem_pkg::AMOMAX_W, 12'h194, vals[1], '0);
    send_req(mem_pkg::AMOMINU_W, 12'h194, vals[0], '0);
    send_req(mem_pkg::LW, 12'h194, '0, '0);
    send_req(mem_pkg::SB, 12'h193, vals[3], '0);
    send_req(mem_pkg::LD, 12'h190, '0, '0);
    finish_test();
    check_latency = 1'b0;
  endtask

  task automatic test_random();
    start_test("random");
    yumi_mode <= 1'b1;
    for (int i = 0; i < 200; i++) begin
      send_req(mem_pkg::opcode_e'(5'(rand_bits(5) % 31)), mem_pkg::addr_t'(rand_bits(6)),
               rand_bits(64), mem_pkg::mask_t'(rand_bits(8)));  // eight words give frequent hazards
      if (rand_bits(2) == 0) idle_cycle();
    end
    finish_test();
    yumi_mode <= 1'b0;
  endtask

  initial begin
    reset_i       = 1'b1;
    v_i           = 1'b0;
    opcode_i      = mem_pkg::LD;
    addr_i        = '0;
    data_i        = '0;
    mask_i        = '0;
    yumi_allow    = 1'b0;
    yumi_mode     = 1'b0;
    stim_lfsr     = 16'd25;
    yumi_lfsr     = 16'd25;
    check_latency = 1'b0;
    cyc           = 0;
    checks        = 0;
    errors        = 0;
    tests         = 0;
    test_name     = "reset";
    vals = '{64'h0000_0000_0000_0007, 64'hffff_ffff_ffff_fff9,
             64'h7654_3210_8000_0001, 64'h8000_0003_1234_5678};
    for (int i = 0; i < mem_pkg::MEM_WORDS; i++) shadow[i] = '0;
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    test_reset();
    test_lanes();
    test_masked();
    test_atomics();
    test_back_to_back();
    test_random();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: mem_access_unit.f
+incdir+include
src/mem_pkg.sv
src/data_ram.sv
src/load_align.sv
src/store_gen.sv
src/mem_access_ctrl.sv
src/mem_access_unit.sv
sim/mem_access_unit_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = mem_access_unit_tb
FILELIST  = mem_access_unit.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "test passed" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
